// ==== design/mem_tester_cfg_pkg.sv ====
// memory tester register map and software-visible words.
// holds APB offsets, control and status bit positions and the config/status structs.
package mem_tester_cfg_pkg;

  localparam int apb_addr_width = 12;
  localparam int apb_data_width = 32;

  localparam logic [apb_addr_width-1:0] addr_ctrl      = 12'h000;
  localparam logic [apb_addr_width-1:0] addr_count     = 12'h004;
  localparam logic [apb_addr_width-1:0] addr_pattern   = 12'h008;
  localparam logic [apb_addr_width-1:0] addr_status    = 12'h00C;
  localparam logic [apb_addr_width-1:0] addr_err_count = 12'h010;
  localparam logic [apb_addr_width-1:0] addr_err_addr  = 12'h014;

  // bit positions inside CTRL and STATUS.
  localparam int ctrl_start_bit  = 0;
  localparam int ctrl_mode_bit   = 1;
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  localparam int count_width    = 7;
  localparam int err_addr_width = 6;
  localparam logic [count_width-1:0] max_count = 7'd64;

  typedef enum logic {
    mode_store_load = 1'b0,
    mode_load_only  = 1'b1
  } test_mode_e;

  typedef struct packed {
    logic [count_width-1:0]    count;
    logic [apb_data_width-1:0] pattern;
    test_mode_e                mode;
  } test_cfg_t;

  typedef struct packed {
    logic                      busy;
    logic                      done;
    logic [count_width-1:0]    err_count;
    logic [err_addr_width-1:0] first_err_addr;
  } test_status_t;

endpackage

// ==== design/mem_tester_pkt_pkg.sv ====
// memory tester packet definitions.
// request and response words between the sequencer and the memory target.
package mem_tester_pkt_pkg;

  localparam int mem_words      = 64;
  localparam int mem_addr_width = 6;
  localparam int data_width     = 32;
  localparam int max_credits    = 4;
  localparam int credit_width   = $clog2(max_credits + 1);

  // response queue inside the target.
  localparam int rsp_fifo_depth     = 2;
  localparam int rsp_fifo_ptr_width = $clog2(rsp_fifo_depth);
  localparam int rsp_fifo_cnt_width = $clog2(rsp_fifo_depth + 1);

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

  // a load tag is the word index.
  typedef logic [mem_addr_width-1:0] load_tag_t;

  typedef struct packed {
    logic [data_width-mem_addr_width-1:0] pad;
    load_tag_t                            id;
  } tag_word_t;

  // stores carry data, loads carry their tag.
  typedef union packed {
    logic [data_width-1:0] store_data;
    tag_word_t             tag;
  } mem_payload_u;

  typedef struct packed {
    mem_op_e                   op;
    logic [mem_addr_width-1:0] addr;
    mem_payload_u              payload;
  } mem_req_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    load_tag_t             tag;
  } mem_rsp_t;

endpackage

// ==== design/mem_tester_regs.sv ====
// memory tester APB register block.
// holds count, pattern and mode, issues the start pulse and returns status.
`timescale 1ns/1ps

module mem_tester_regs (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic [mem_tester_cfg_pkg::apb_addr_width-1:0] paddr_i,
  input  logic                                         psel_i,
  input  logic                                         penable_i,
  input  logic                                         pwrite_i,
  input  logic [mem_tester_cfg_pkg::apb_data_width-1:0] pwdata_i,
  output logic [mem_tester_cfg_pkg::apb_data_width-1:0] prdata_o,
  output logic                                         pready_o,
  output logic                                         pslverr_o,
  input  mem_tester_cfg_pkg::test_status_t             status_i,
  output mem_tester_cfg_pkg::test_cfg_t                cfg_o,
  output logic                                         start_o
);
  import mem_tester_cfg_pkg::*;

  test_cfg_t cfg_r;
  logic      start_r;
  logic      access;
  logic      wr_access;
  logic      mapped;
  logic      cfg_addr;
  logic      busy;
  logic      count_ok;
  logic      start_req;
  logic      wr_err;
  logic      start_err;
  logic      wr_ok;

  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;
  assign cfg_addr  = (paddr_i == addr_ctrl) | (paddr_i == addr_count) |
                     (paddr_i == addr_pattern);

  // a pending start counts as busy too.
  assign busy      = status_i.busy | start_r;
  assign count_ok  = (cfg_r.count != '0) & (cfg_r.count <= max_count);
  assign start_req = wr_access & (paddr_i == addr_ctrl) & pwdata_i[ctrl_start_bit];
  assign wr_err    = wr_access & cfg_addr & busy;
  assign start_err = start_req & ~count_ok;

  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~mapped | wr_err | start_err);
  assign wr_ok     = wr_access & ~pslverr_o;

  always_comb begin
    prdata_o = '0;
    mapped   = 1'b1;
    case (paddr_i)
      addr_ctrl:      prdata_o[ctrl_mode_bit] = cfg_r.mode;
      addr_count:     prdata_o[count_width-1:0] = cfg_r.count;
      addr_pattern:   prdata_o = cfg_r.pattern;
      addr_status: begin
        prdata_o[status_busy_bit] = status_i.busy;
        prdata_o[status_done_bit] = status_i.done;
      end
      addr_err_count: prdata_o[count_width-1:0] = status_i.err_count;
      addr_err_addr:  prdata_o[err_addr_width-1:0] = status_i.first_err_addr;
      default:        mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_r   <= '0;
      start_r <= 1'b0;
    end else begin
      start_r <= wr_ok & start_req;
      if (wr_ok && paddr_i == addr_ctrl) begin
        cfg_r.mode <= test_mode_e'(pwdata_i[ctrl_mode_bit]);
      end
      if (wr_ok && paddr_i == addr_count) begin
        cfg_r.count <= pwdata_i[count_width-1:0];
      end
      if (wr_ok && paddr_i == addr_pattern) begin
        cfg_r.pattern <= pwdata_i;
      end
    end
  end

  assign cfg_o   = cfg_r;
  assign start_o = start_r;

endmodule

// ==== design/mem_tester_master.sv ====
// memory tester sequencer.
// stores pattern words, loads them back under a credit limit and checks each response.
`timescale 1ns/1ps

module mem_tester_master (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  mem_tester_cfg_pkg::test_cfg_t    cfg_i,
  input  logic                             start_i,
  output mem_tester_cfg_pkg::test_status_t status_o,
  output logic                             req_valid_o,
  output mem_tester_pkt_pkg::mem_req_t     req_o,
  input  logic                             req_ready_i,
  input  logic                             rsp_valid_i,
  input  mem_tester_pkt_pkg::mem_rsp_t     rsp_i,
  output logic                             rsp_ready_o,
  input  logic                             rsp_stall_i
);
  import mem_tester_cfg_pkg::*;
  import mem_tester_pkt_pkg::*;

  typedef enum logic [1:0] {
    send_idle,
    send_store,
    send_load,
    send_drain
  } send_state_e;

  send_state_e               send_state_r;
  logic [count_width-1:0]    send_idx_r;
  logic [count_width-1:0]    last_idx;
  logic [credit_width-1:0]   credits_r;
  logic [count_width-1:0]    recv_cnt_r;
  logic [count_width-1:0]    err_count_r;
  logic [err_addr_width-1:0] first_err_r;
  logic                      busy_r;
  logic                      done_r;
  logic                      req_fire;
  logic                      load_fire;
  logic                      rsp_fire;
  logic                      send_last;
  logic                      recv_last;
  logic [data_width-1:0]     expected;
  logic                      mismatch;

  assign last_idx  = cfg_i.count - 1'b1;
  assign send_last = send_idx_r == last_idx;
  assign recv_last = recv_cnt_r == last_idx;
  assign req_fire  = req_valid_o & req_ready_i;
  assign load_fire = req_fire & (send_state_r == send_load);

  assign rsp_ready_o = ~rsp_stall_i;
  assign rsp_fire    = rsp_valid_i & rsp_ready_o;
  assign expected    = cfg_i.pattern + data_width'(rsp_i.tag);
  assign mismatch    = rsp_i.data != expected;

  always_comb begin
    req_o       = '0;
    req_valid_o = 1'b0;
    req_o.addr  = send_idx_r[mem_addr_width-1:0];
    case (send_state_r)
      send_store: begin
        req_valid_o              = 1'b1;
        req_o.op                 = op_store;
        req_o.payload.store_data = cfg_i.pattern + data_width'(send_idx_r);
      end
      send_load: begin
        // hold off while every credit is in use.
        req_valid_o          = credits_r < credit_width'(max_credits);
        req_o.op             = op_load;
        req_o.payload.tag.id = send_idx_r[mem_addr_width-1:0];
      end
      default: req_valid_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= send_idle;
      send_idx_r   <= '0;
    end else begin
      case (send_state_r)
        send_idle: begin
          if (start_i) begin
            send_idx_r   <= '0;
            send_state_r <= (cfg_i.mode == mode_store_load) ? send_store : send_load;
          end
        end
        send_store, send_load: begin
          if (req_fire && send_last) begin
            send_idx_r   <= '0;
            send_state_r <= (send_state_r == send_store) ? send_load : send_drain;
          end else if (req_fire) begin
            send_idx_r <= send_idx_r + 1'b1;
          end
        end
        default: begin
          if (rsp_fire && recv_last) begin
            send_state_r <= send_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= '0;
    end else if (load_fire && !rsp_fire) begin
      credits_r <= credits_r + 1'b1;
    end else if (rsp_fire && !load_fire) begin
      credits_r <= credits_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r      <= 1'b0;
      done_r      <= 1'b0;
      recv_cnt_r  <= '0;
      err_count_r <= '0;
      first_err_r <= '0;
    end else if (start_i) begin
      busy_r      <= 1'b1;
      done_r      <= 1'b0;
      recv_cnt_r  <= '0;
      err_count_r <= '0;
      first_err_r <= '0;
    end else if (rsp_fire) begin
      recv_cnt_r <= recv_cnt_r + 1'b1;
      if (mismatch) begin
        err_count_r <= err_count_r + 1'b1;
        // responses return in order, so the first one is the lowest index.
        if (err_count_r == '0) begin
          first_err_r <= rsp_i.tag;
        end
      end
      if (recv_last) begin
        busy_r <= 1'b0;
        done_r <= 1'b1;
      end
    end
  end

  assign status_o.busy           = busy_r;
  assign status_o.done           = done_r;
  assign status_o.err_count      = err_count_r;
  assign status_o.first_err_addr = first_err_r;

endmodule

// ==== design/mem_tester_target.sv ====
// memory tester local target.
// word memory that serves stores and loads and queues load responses.
`timescale 1ns/1ps

module mem_tester_target (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_valid_i,
  input  mem_tester_pkt_pkg::mem_req_t req_i,
  output logic                         req_ready_o,
  output logic                         rsp_valid_o,
  output mem_tester_pkt_pkg::mem_rsp_t rsp_o,
  input  logic                         rsp_ready_i
);
  import mem_tester_pkt_pkg::*;

  logic [data_width-1:0]         mem [mem_words];
  mem_rsp_t                      fifo_q [rsp_fifo_depth];
  mem_rsp_t                      rd_rsp_r;
  logic                          rd_valid_r;
  logic [rsp_fifo_ptr_width-1:0] wr_ptr_r;
  logic [rsp_fifo_ptr_width-1:0] rd_ptr_r;
  logic [rsp_fifo_cnt_width-1:0] fifo_cnt_r;
  logic [rsp_fifo_cnt_width-1:0] occupancy;
  logic                          req_fire;
  logic                          store_fire;
  logic                          load_fire;
  logic                          fifo_pop;

  // a read in flight already owns a FIFO slot.
  assign occupancy   = fifo_cnt_r + rsp_fifo_cnt_width'(rd_valid_r);
  assign req_ready_o = occupancy < rsp_fifo_cnt_width'(rsp_fifo_depth);

  assign req_fire   = req_valid_i & req_ready_o;
  assign store_fire = req_fire & (req_i.op == op_store);
  assign load_fire  = req_fire & (req_i.op == op_load);

  assign rsp_valid_o = fifo_cnt_r != '0;
  assign rsp_o       = fifo_q[rd_ptr_r];
  assign fifo_pop    = rsp_valid_o & rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (store_fire) begin
      mem[req_i.addr] <= req_i.payload.store_data;
    end
    if (load_fire) begin
      rd_rsp_r.data <= mem[req_i.addr];
      rd_rsp_r.tag  <= req_i.payload.tag.id;
    end
    if (rd_valid_r) begin
      fifo_q[wr_ptr_r] <= rd_rsp_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_r <= 1'b0;
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      fifo_cnt_r <= '0;
    end else begin
      rd_valid_r <= load_fire;
      if (rd_valid_r) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      if (rd_valid_r && !fifo_pop) begin
        fifo_cnt_r <= fifo_cnt_r + 1'b1;
      end else if (fifo_pop && !rd_valid_r) begin
        fifo_cnt_r <= fifo_cnt_r - 1'b1;
      end
    end
  end

endmodule

// ==== design/mem_tester_top.sv ====
// memory tester top level.
// joins the APB register block, the sequencer and the local memory target.
`timescale 1ns/1ps

module mem_tester_top (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic [mem_tester_cfg_pkg::apb_addr_width-1:0] paddr_i,
  input  logic                                         psel_i,
  input  logic                                         penable_i,
  input  logic                                         pwrite_i,
  input  logic [mem_tester_cfg_pkg::apb_data_width-1:0] pwdata_i,
  output logic [mem_tester_cfg_pkg::apb_data_width-1:0] prdata_o,
  output logic                                         pready_o,
  output logic                                         pslverr_o,
  input  logic                                         rsp_stall_i
);
  import mem_tester_cfg_pkg::*;
  import mem_tester_pkt_pkg::*;

  test_cfg_t    cfg;
  test_status_t status;
  logic         start;
  mem_req_t     req;
  logic         req_valid;
  logic         req_ready;
  mem_rsp_t     rsp;
  logic         rsp_valid;
  logic         rsp_ready;

  mem_tester_regs u_regs (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .status_i  (status),
    .cfg_o     (cfg),
    .start_o   (start)
  );

  mem_tester_master u_master (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_i       (cfg),
    .start_i     (start),
    .status_o    (status),
    .req_valid_o (req_valid),
    .req_o       (req),
    .req_ready_i (req_ready),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .rsp_ready_o (rsp_ready),
    .rsp_stall_i (rsp_stall_i)
  );

  mem_tester_target u_target (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready)
  );

endmodule

// ==== tb/mem_tester_properties.sv ====
// memory tester handshake checks.
// bound into the sequencer to watch request, response and credit rules.
`timescale 1ns/1ps

module mem_tester_properties (
  input logic                                      clk_i,
  input logic                                      reset_i,
  input logic                                      req_valid_i,
  input mem_tester_pkt_pkg::mem_req_t              req_i,
  input logic                                      req_ready_i,
  input logic                                      rsp_valid_i,
  input mem_tester_pkt_pkg::mem_rsp_t              rsp_i,
  input logic                                      rsp_ready_i,
  input logic [mem_tester_pkt_pkg::credit_width-1:0] credits_i,
  input mem_tester_cfg_pkg::test_status_t          status_i
);
  import mem_tester_pkt_pkg::*;

  req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("request dropped or changed before its transfer");

  // a stalled response must wait unchanged.
  rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response dropped or changed while stalled");

  credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_i <= credit_width'(max_credits))
    else $error("outstanding loads above the credit limit");

  done_not_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    !(status_i.done && status_i.busy))
    else $error("done and busy set together");

endmodule

bind mem_tester_master mem_tester_properties u_properties (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_o),
  .req_i       (req_o),
  .req_ready_i (req_ready_i),
  .rsp_valid_i (rsp_valid_i),
  .rsp_i       (rsp_i),
  .rsp_ready_i (rsp_ready_o),
  .credits_i   (credits_r),
  .status_i    (status_o)
);

// ==== tb/mem_tester_tb.sv ====
// memory tester testbench.
// programs runs over APB from a stimulus file and checks the status of each run.
`timescale 1ns/1ps

module mem_tester_tb;
  import mem_tester_cfg_pkg::*;

  localparam int clk_period   = 40;
  localparam int poll_timeout = 2000;

  logic                      clk;
  logic                      reset;
  logic [apb_addr_width-1:0] paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_data_width-1:0] pwdata;
  logic [apb_data_width-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      rsp_stall;
  logic [31:0]               rng_state;
  int                        stall_pct;

  mem_tester_top u_mem_tester_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .rsp_stall_i (rsp_stall)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // back-pressure on the response channel at the current stall rate.
  initial begin
    rsp_stall = 1'b0;
    rng_state = 32'd10904;
    forever begin
      @(posedge clk);
      rng_state = next_random(rng_state);
      rsp_stall <= (rng_state % 32'd100) < 32'(stall_pct);
    end
  end

  task automatic report_mismatch(input string msg);
    $display("ERR t=%0t %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_rdata(input logic [apb_data_width-1:0] got,
                             input logic [apb_data_width-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s read 0x%08h, expected 0x%08h", what, got, exp));
    end
  endtask

  task automatic check_slverr(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s pslverr %0b, expected %0b", what, got, exp));
    end
  endtask

  task automatic check_pready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s pready %0b, expected %0b", what, got, exp));
    end
  endtask

  task automatic check_status(input test_status_t got, input test_status_t exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s busy=%0d done=%0d errs=%0d first=%0d, expected %0d %0d %0d %0d",
        what, got.busy, got.done, got.err_count, got.first_err_addr,
        exp.busy, exp.done, exp.err_count, exp.first_err_addr));
    end
  endtask

  // one setup cycle, then the access cycle sampled on the falling edge.
  task automatic apb_transfer(input logic write, input logic [apb_addr_width-1:0] addr,
                              input logic [apb_data_width-1:0] wdata,
                              output logic [apb_data_width-1:0] rdata, output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    // no wait states, so the first access cycle completes the transfer.
    check_pready(pready, 1'b1, $sformatf("access to 0x%03h", addr));
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_reg(input logic [apb_addr_width-1:0] addr,
                           input logic [apb_data_width-1:0] data, input logic exp_err,
                           input string what);
    logic [apb_data_width-1:0] rdata;
    logic                      slverr;
    apb_transfer(1'b1, addr, data, rdata, slverr);
    check_slverr(slverr, exp_err, what);
  endtask

  task automatic read_reg(input logic [apb_addr_width-1:0] addr,
                          output logic [apb_data_width-1:0] rdata);
    logic slverr;
    apb_transfer(1'b0, addr, '0, rdata, slverr);
    check_slverr(slverr, 1'b0, $sformatf("read of 0x%03h", addr));
  endtask

  task automatic wait_done();
    logic [apb_data_width-1:0] rdata;
    int                        polls;
    polls = 0;
    read_reg(addr_status, rdata);
    while (!rdata[status_done_bit]) begin
      if (polls == poll_timeout) begin
        report_failure("timeout: STATUS never showed done after a start");
      end
      polls++;
      read_reg(addr_status, rdata);
    end
  endtask

  task automatic run_test(input int mode, input int count, input logic [31:0] pattern,
                          input int stall, input int exp_err, input int exp_first,
                          input int run_idx);
    logic [apb_data_width-1:0] rdata;
    test_status_t              got;
    test_status_t              exp;
    stall_pct = stall;
    write_reg(addr_count, apb_data_width'(count), 1'b0, "COUNT write");
    write_reg(addr_pattern, pattern, 1'b0, "PATTERN write");
    write_reg(addr_ctrl, apb_data_width'((mode << ctrl_mode_bit) | 1), 1'b0, "start");
    if (run_idx == 0) begin
      // configuration is locked while a run is going.
      write_reg(addr_count, 32'd5, 1'b1, "COUNT write while busy");
      read_reg(addr_count, rdata);
      check_rdata(rdata, apb_data_width'(count), "COUNT after refused write");
    end
    wait_done();
    stall_pct = 0;
    read_reg(addr_status, rdata);
    got.busy = rdata[status_busy_bit];
    got.done = rdata[status_done_bit];
    read_reg(addr_err_count, rdata);
    got.err_count = rdata[count_width-1:0];
    read_reg(addr_err_addr, rdata);
    got.first_err_addr = rdata[err_addr_width-1:0];
    exp.busy           = 1'b0;
    exp.done           = 1'b1;
    exp.err_count      = count_width'(exp_err);
    exp.first_err_addr = err_addr_width'(exp_first);
    check_status(got, exp, $sformatf("run %0d", run_idx));
  endtask

  initial begin
    int                        fd;
    int                        n;
    int                        runs;
    int                        mode;
    int                        count;
    int                        stall;
    int                        exp_err;
    int                        exp_first;
    logic [31:0]               pattern;
    logic [apb_data_width-1:0] rdata;
    logic                      slverr;
    string                     line;
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    stall_pct = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < 6; i++) begin
      read_reg(apb_addr_width'(4 * i), rdata);
      check_rdata(rdata, '0, $sformatf("reset value at 0x%03h", 4 * i));
    end
    write_reg(addr_count, 32'd64, 1'b0, "COUNT write");
    write_reg(addr_pattern, 32'hdeadbeef, 1'b0, "PATTERN write");
    read_reg(addr_count, rdata);
    check_rdata(rdata, 32'd64, "COUNT readback");
    read_reg(addr_pattern, rdata);
    check_rdata(rdata, 32'hdeadbeef, "PATTERN readback");

    apb_transfer(1'b0, 12'h018, '0, rdata, slverr);
    check_slverr(slverr, 1'b1, "unmapped read");
    write_reg(12'h01c, 32'h1, 1'b1, "unmapped write");
    write_reg(addr_count, 32'd0, 1'b0, "COUNT zero write");
    write_reg(addr_ctrl, 32'h1, 1'b1, "start with count 0");
    read_reg(addr_status, rdata);
    check_rdata(rdata, '0, "STATUS after refused start");

    fd = $fopen("tb/mem_tester_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("could not open tb/mem_tester_stimulus.txt");
    end
    runs = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %h %d %d %d", mode, count, pattern, stall, exp_err, exp_first);
      if (n <= 0) begin
        continue;
      end
      if (n != 6) begin
        report_failure($sformatf("malformed stimulus line: %s", line));
      end
      run_test(mode, count, pattern, stall, exp_err, exp_first, runs);
      runs++;
    end
    $fclose(fd);
    if (runs == 0) begin
      report_failure("the stimulus file held no test runs");
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== mem_tester.f ====
design/mem_tester_cfg_pkg.sv
design/mem_tester_pkt_pkg.sv
design/mem_tester_regs.sv
design/mem_tester_master.sv
design/mem_tester_target.sv
design/mem_tester_top.sv
tb/mem_tester_properties.sv
tb/mem_tester_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory tester.
VERILATOR ?= verilator
TOP       ?= mem_tester_tb
FILELIST  ?= mem_tester.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/mem_tester_stimulus.txt ====
# mode (0 store then load, 1 load only), count, pattern in hex, stall percent,
# expected error count, expected first error address
0 64 12345678 0 0 0
1 64 a5a50000 0 64 0
0 64 cafe0000 50 0 0
1 64 cafe0000 75 0 0
0 16 00001000 0 0 0
1 32 00001000 25 16 16
